// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wno-fatal
TOP       ?= tb_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  rv_pkg::alu_op_t         op,
    input  logic [rv_pkg::xlen-1:0] lhs,
    input  logic [rv_pkg::xlen-1:0] rhs,
    output logic [rv_pkg::xlen-1:0] res
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = rhs[4:0];
    assign lt_s = $signed(lhs) < $signed(rhs);
    assign lt_u = lhs < rhs;
    assign eq = (lhs == rhs);

    always_comb begin
        case (op)
            alu_add:  res = lhs + rhs;
            alu_sub:  res = lhs - rhs;
            alu_sll:  res = lhs << shamt;
            alu_slt:  res = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu: res = {{(xlen-1){1'b0}}, lt_u};
            alu_xor:  res = lhs ^ rhs;
            alu_srl:  res = lhs >> shamt;
            alu_sra:  res = $signed(lhs) >>> shamt;
            alu_or:   res = lhs | rhs;
            alu_and:  res = lhs & rhs;
            alu_eq:   res = {{(xlen-1){1'b0}}, eq};
            alu_ne:   res = {{(xlen-1){1'b0}}, !eq};
            alu_ge:   res = {{(xlen-1){1'b0}}, !lt_s};
            alu_geu:  res = {{(xlen-1){1'b0}}, !lt_u};
            default:  res = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/core_control.sv
`timescale 1ns/10ps
`default_nettype none

module core_control (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          ready,
    input  logic [rv_pkg::xlen-1:0]       read_data,
    input  logic                          read_data_valid,
    output rv_pkg::mem_req_t              mem_req,
    output logic [rv_pkg::xlen-1:0]       instruction,
    input  rv_pkg::decoded_t              dec,
    input  logic [rv_pkg::xlen-1:0]       rs1_value,
    input  logic [rv_pkg::xlen-1:0]       rs2_value,
    output rv_pkg::alu_op_t               alu_op,
    output logic [rv_pkg::xlen-1:0]       alu_lhs,
    output logic [rv_pkg::xlen-1:0]       alu_rhs,
    input  logic [rv_pkg::xlen-1:0]       alu_res,
    input  logic [rv_pkg::xlen-1:0]       pc,
    input  logic [rv_pkg::xlen-1:0]       link_pc,
    output rv_pkg::pc_sel_t               pc_sel,
    output logic                          pc_load,
    output logic                          wr_en,
    output logic [rv_pkg::reg_addr_w-1:0] wr_addr,
    output logic [rv_pkg::xlen-1:0]       wr_data
);
    import rv_pkg::*;

    core_state_t     state;
    logic [1:0]      lane;
    logic [3:0]      size_mask;
    logic            crossing;
    logic [xlen-1:0] load_shifted;
    logic [xlen-1:0] load_aligned;
    logic [xlen-1:0] load_value;
    logic            writes_rd;
    logic            wb_fire;

    // byte offset inside the word
    assign lane = alu_res[1:0];

    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   size_mask = 4'b0001;
            2'b01:   size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
        crossing = (dec.funct3[1:0] == 2'b01 && lane == 2'b11) ||
                   (dec.funct3[1:0] == 2'b10 && lane != 2'b00);
    end

    assign load_shifted = read_data >> {lane, 3'b000};

    always_comb begin
        case (dec.funct3)
            3'b000:  load_aligned = {{24{load_shifted[7]}}, load_shifted[7:0]};
            3'b001:  load_aligned = {{16{load_shifted[15]}}, load_shifted[15:0]};
            3'b100:  load_aligned = {24'b0, load_shifted[7:0]};
            3'b101:  load_aligned = {16'b0, load_shifted[15:0]};
            default: load_aligned = load_shifted;
        endcase
    end

    // writeback waits for a pending store to be accepted
    assign wb_fire = (state == st_writeback) && (!mem_req.write_req || ready);
    assign pc_load = wb_fire;
    assign wr_en = wb_fire && writes_rd;
    assign wr_addr = dec.rd;

    always_comb begin
        writes_rd = 1'b0;
        wr_data = alu_res;
        pc_sel = pc_seq;
        case (dec.opcode)
            opc_lui, opc_auipc, opc_op_imm, opc_op: writes_rd = 1'b1;
            opc_jal: begin
                writes_rd = 1'b1;
                wr_data = link_pc;
                pc_sel = pc_alu;
            end
            opc_jalr: begin
                writes_rd = 1'b1;
                wr_data = link_pc;
                pc_sel = pc_jalr;
            end
            opc_branch: pc_sel = pc_branch;
            opc_load: begin
                writes_rd = 1'b1;
                wr_data = load_value;
            end
            default: writes_rd = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_fetch_setup;
            mem_req <= '0;
        end else begin
            case (state)
                st_fetch_setup: begin
                    if (pc[1:0] != 2'b00) begin
                        state <= st_halted;
                    end else begin
                        mem_req.addr <= pc;
                        mem_req.byte_enable <= 4'hf;
                        mem_req.read_req <= 1'b1;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (ready) begin
                        mem_req.read_req <= 1'b0;
                    end
                    if (read_data_valid) begin
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    if (dec.illegal) begin
                        state <= st_halted;
                    end else if (dec.opcode == opc_load) begin
                        state <= st_mem_load;
                    end else if (dec.opcode == opc_store) begin
                        state <= st_mem_store;
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_mem_load: begin
                    if (crossing) begin
                        state <= st_halted;
                    end else begin
                        mem_req.addr <= {alu_res[xlen-1:2], 2'b00};
                        mem_req.byte_enable <= size_mask << lane;
                        mem_req.read_req <= 1'b1;
                        state <= st_mem_load_wait;
                    end
                end
                st_mem_load_wait: begin
                    if (ready) begin
                        mem_req.read_req <= 1'b0;
                    end
                    if (read_data_valid) begin
                        state <= st_writeback;
                    end
                end
                st_mem_store: begin
                    if (crossing) begin
                        state <= st_halted;
                    end else begin
                        mem_req.addr <= {alu_res[xlen-1:2], 2'b00};
                        mem_req.byte_enable <= size_mask << lane;
                        mem_req.write_data <= rs2_value << {lane, 3'b000};
                        mem_req.write_req <= 1'b1;
                        state <= st_writeback;
                    end
                end
                st_writeback: begin
                    if (wb_fire) begin
                        mem_req.write_req <= 1'b0;
                        state <= st_fetch_setup;
                    end
                end
                st_halted: state <= st_halted;
                default: state <= st_halted;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && read_data_valid) begin
            instruction <= read_data;
        end
        if (state == st_mem_load_wait && read_data_valid) begin
            load_value <= load_aligned;
        end
        // operands held stable through memory and writeback
        if (state == st_decode) begin
            alu_op <= dec.alu_op;
            case (dec.lhs_sel)
                lhs_pc:   alu_lhs <= pc;
                lhs_zero: alu_lhs <= '0;
                default:  alu_lhs <= rs1_value;
            endcase
            alu_rhs <= (dec.rhs_sel == rhs_imm) ? dec.imm : rs2_value;
        end
    end

endmodule

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    ready,
    input  logic [rv_pkg::xlen-1:0] read_data,
    input  logic                    read_data_valid,
    output rv_pkg::mem_req_t        mem_req
);
    import rv_pkg::*;

    logic [xlen-1:0]       instruction;
    decoded_t              dec;
    logic [xlen-1:0]       rs1_value;
    logic [xlen-1:0]       rs2_value;
    alu_op_t               alu_op;
    logic [xlen-1:0]       alu_lhs;
    logic [xlen-1:0]       alu_rhs;
    logic [xlen-1:0]       alu_res;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       link_pc;
    pc_sel_t               pc_sel;
    logic                  pc_load;
    logic                  wr_en;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0]       wr_data;

    core_control u_control (
        .clk             (clk),
        .reset_n         (reset_n),
        .ready           (ready),
        .read_data       (read_data),
        .read_data_valid (read_data_valid),
        .mem_req         (mem_req),
        .instruction     (instruction),
        .dec             (dec),
        .rs1_value       (rs1_value),
        .rs2_value       (rs2_value),
        .alu_op          (alu_op),
        .alu_lhs         (alu_lhs),
        .alu_rhs         (alu_rhs),
        .alu_res         (alu_res),
        .pc              (pc),
        .link_pc         (link_pc),
        .pc_sel          (pc_sel),
        .pc_load         (pc_load),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data)
    );

    instr_decoder u_decoder (
        .instruction (instruction),
        .dec         (dec)
    );

    reg_file u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu u_alu (
        .op  (alu_op),
        .lhs (alu_lhs),
        .rhs (alu_rhs),
        .res (alu_res)
    );

    pc_unit u_pc (
        .clk           (clk),
        .reset_n       (reset_n),
        .pc_sel        (pc_sel),
        .pc_load       (pc_load),
        .alu_res       (alu_res),
        .branch_offset (dec.branch_offset),
        .pc            (pc),
        .link_pc       (link_pc)
    );

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  logic [rv_pkg::xlen-1:0] instruction,
    output rv_pkg::decoded_t        dec
);
    import rv_pkg::*;

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            funct7_zero;
    logic            funct7_alt;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    endfunction

    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign funct7_zero = (funct7 == 7'b0000000);
    assign funct7_alt = (funct7 == 7'b0100000);

    assign i_imm = {{20{instruction[31]}}, instruction[31:20]};
    assign s_imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign u_imm = {instruction[31:12], 12'h000};
    assign j_imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};

    always_comb begin
        dec.opcode = opcode_t'(instruction[6:0]);
        dec.funct3 = funct3;
        dec.rd = instruction[11:7];
        dec.rs1 = instruction[19:15];
        dec.rs2 = instruction[24:20];
        dec.alu_op = alu_add;
        dec.lhs_sel = lhs_rs1;
        dec.rhs_sel = rhs_imm;
        dec.imm = i_imm;
        dec.branch_offset = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
        dec.illegal = 1'b0;

        case (dec.opcode)
            opc_lui: begin
                dec.lhs_sel = lhs_zero;
                dec.imm = u_imm;
            end
            opc_auipc: begin
                dec.lhs_sel = lhs_pc;
                dec.imm = u_imm;
            end
            opc_jal: begin
                dec.lhs_sel = lhs_pc;
                dec.imm = j_imm;
            end
            opc_jalr: dec.illegal = (funct3 != 3'b000);
            opc_branch: begin
                dec.rhs_sel = rhs_rs2;
                case (funct3)
                    3'b000:  dec.alu_op = alu_eq;
                    3'b001:  dec.alu_op = alu_ne;
                    3'b100:  dec.alu_op = alu_slt;
                    3'b101:  dec.alu_op = alu_ge;
                    3'b110:  dec.alu_op = alu_sltu;
                    3'b111:  dec.alu_op = alu_geu;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opc_load: dec.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            opc_store: begin
                dec.imm = s_imm;
                dec.illegal = (funct3[2] || funct3[1:0] == 2'b11);
            end
            opc_op_imm: begin
                dec.alu_op = arith_op(funct3, funct3 == 3'b101 && instruction[30]);
                // shift amount sits in the rs2 field
                if (funct3[1:0] == 2'b01) begin
                    dec.imm = {27'b0, instruction[24:20]};
                    dec.illegal = !(funct7_zero || (funct3 == 3'b101 && funct7_alt));
                end
            end
            opc_op: begin
                dec.alu_op = arith_op(funct3, instruction[30]);
                dec.rhs_sel = rhs_rs2;
                dec.illegal = !(funct7_zero ||
                                (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            opc_fence: dec.illegal = 1'b0;
            // only ecall/ebreak, csr accesses halt
            opc_system: dec.illegal = (funct3 != 3'b000);
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
    input  logic                    clk,
    input  logic                    reset_n,
    input  rv_pkg::pc_sel_t         pc_sel,
    input  logic                    pc_load,
    input  logic [rv_pkg::xlen-1:0] alu_res,
    input  logic [rv_pkg::xlen-1:0] branch_offset,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] link_pc
);
    import rv_pkg::*;

    logic [xlen-1:0] next_pc;

    assign link_pc = pc + 32'd4;

    always_comb begin
        case (pc_sel)
            pc_alu:    next_pc = alu_res;
            pc_jalr:   next_pc = {alu_res[xlen-1:1], 1'b0};
            // branch condition comes back in bit zero
            pc_branch: next_pc = alu_res[0] ? pc + branch_offset : link_pc;
            default:   next_pc = link_pc;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= reset_pc;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]       rs1_value,
    output logic [rv_pkg::xlen-1:0]       rs2_value,
    input  logic                          wr_en,
    input  logic [rv_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [rv_pkg::xlen-1:0]       wr_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:num_regs];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i <= num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 is hardwired
    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs = 31;
    localparam logic [xlen-1:0] reset_pc = 32'h1000_0000;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_fence  = 7'b0001111,
        opc_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl,
        alu_sra, alu_or, alu_and, alu_eq, alu_ne, alu_ge, alu_geu
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch_setup, st_fetch, st_decode, st_mem_load,
        st_mem_load_wait, st_mem_store, st_writeback, st_halted
    } core_state_t;

    typedef enum logic [1:0] {lhs_rs1, lhs_pc, lhs_zero} lhs_sel_t;

    typedef enum logic {rhs_rs2, rhs_imm} rhs_sel_t;

    typedef enum logic [1:0] {pc_seq, pc_alu, pc_jalr, pc_branch} pc_sel_t;

    typedef struct packed {
        opcode_t               opcode;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        alu_op_t               alu_op;
        lhs_sel_t              lhs_sel;
        rhs_sel_t              rhs_sel;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       branch_offset;
        logic                  illegal;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   write_data;
        logic [xlen/8-1:0] byte_enable;
        logic              read_req;
        logic              write_req;
    } mem_req_t;

endpackage

`default_nettype wire

// File: tb.f
hw/rv_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/pc_unit.sv
hw/core_control.sv
hw/core_top.sv
tb/tb_core.sv

// File: tb/core_trace.txt
// word 0 is the program length, word 1 the store count, then the program words,
// then one line per expected store: word address, byte_enable, data on the enabled lanes
00000024
0000000D
100000B7 10008093 FFB00113 40115193 // lui, addi base, addi -5, srai
0030A023 00012233 402202B3 00429293 // sw, slt, sub, slli
0022C2B3 0050A223 00001317 0060A423 // xor, sw, auipc, sw
00020463 00021463 0020A623 008003EF // beq not taken, bne taken, skipped sw, jal
0020A623 0070A623 01038467 0020A623 // skipped sw, sw link, jalr, skipped sw
0080A823 00208AA3 00509D23 01508483 // sw link, sb lane 1, sh lane 2, lb
0150C503 01A09583 01A0D603 0000A683 // lbu, lh, lhu, lw
0090AE23 02A0A023 02B0A223 02C0A423 // copies of the loaded values
02D0A623 024089A3 0FF0000F 00000000 // sw, sb lane 3, fence, illegal
10000100 F FFFFFFFD
10000104 F FFFFFF9B
10000108 F 10001028
1000010C F 10000040
10000110 F 1000004C
10000114 2 0000FB00
10000118 C FF9B0000
1000011C F FFFFFFFB
10000120 F 000000FB
10000124 F FFFFFF9B
10000128 F 0000FF9B
1000012C F FFFFFFFD
10000130 8 01000000

// File: tb/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core;
    import rv_pkg::*;

    localparam int cycle_ns = 40;
    localparam int reset_cycles = 5;
    localparam int mem_words = 256;
    localparam int trace_depth = 128;
    localparam int max_stall = 3;
    // generous bound covering bus stalls on fetch, load and store
    localparam int worst_cycles_per_instr = 40;
    localparam int quiet_cycles = 40;
    // the fence and the illegal word follow the last store
    localparam int tail_fetches = 2;

    logic            clk;
    logic            reset_n;
    logic            ready;
    logic [xlen-1:0] read_data;
    logic            read_data_valid;
    mem_req_t        mem_req;

    logic [31:0] mem [0:mem_words-1];
    logic [31:0] trace [0:trace_depth-1];

    int          num_words;
    int          num_stores;
    int          stores_seen;
    int          reads_after_stores;
    int          stall_run;
    int          resp_delay;
    bit          resp_pending;
    logic [31:0] resp_word;
    bit          first_req_seen;
    bit          held_valid;
    mem_req_t    held_req;
    bit          quiet_phase;
    bit          trace_loaded;

    core_top dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .ready           (ready),
        .read_data       (read_data),
        .read_data_valid (read_data_valid),
        .mem_req         (mem_req)
    );

    always #(cycle_ns / 2) clk = ~clk;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic bit in_memory(input logic [31:0] addr);
        return (addr - reset_pc) < 32'(mem_words * 4);
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // bus memory model driven and sampled on the falling edge
    always @(negedge clk) begin
        int          idx;
        int          base;
        logic [31:0] mask;
        logic [31:0] exp_addr;
        logic [3:0]  exp_be;
        logic [31:0] exp_data;
        if (!reset_n) begin
            ready = 1'b0;
            read_data_valid = 1'b0;
            held_valid = 1'b0;
            resp_pending = 1'b0;
            stall_run = 0;
        end else begin
            if (held_valid && !ready) begin
                assert (mem_req == held_req) else
                    stop_run($sformatf("[FAIL] %0t ns: request changed while stalled, %h -> %h",
                                       $time, held_req, mem_req));
            end
            // request held across the last rising edge with ready high was accepted
            if (held_valid && ready) begin
                assert (in_memory(held_req.addr)) else
                    stop_run($sformatf("bus access outside the memory model at address %h",
                                       held_req.addr));
                idx = int'((held_req.addr - reset_pc) >> 2);
                if (held_req.read_req) begin
                    resp_pending = 1'b1;
                    resp_delay = int'($urandom % 3);
                    // disabled lanes return inverted data
                    resp_word = mem[idx] ^ ~lane_mask(held_req.byte_enable);
                    if (stores_seen == num_stores) begin
                        reads_after_stores++;
                    end
                end
                if (held_req.write_req) begin
                    assert (stores_seen < num_stores) else
                        stop_run("a store occurred after the last expected store");
                    base = 2 + num_words + 3 * stores_seen;
                    exp_addr = trace[base];
                    exp_be = trace[base+1][3:0];
                    exp_data = trace[base+2];
                    mask = lane_mask(exp_be);
                    assert (held_req.addr == exp_addr && held_req.byte_enable == exp_be &&
                            (held_req.write_data & mask) == (exp_data & mask)) else
                        stop_run($sformatf(
                            "[FAIL] %0t ns: store %0d got %h/%h/%h, expected %h/%h/%h",
                            $time, stores_seen, held_req.addr, held_req.byte_enable,
                            held_req.write_data & mask, exp_addr, exp_be, exp_data));
                    for (int b = 0; b < 4; b++) begin
                        if (held_req.byte_enable[b]) begin
                            mem[idx][8*b +: 8] = held_req.write_data[8*b +: 8];
                        end
                    end
                    stores_seen++;
                end
            end
            read_data_valid = 1'b0;
            if (resp_pending) begin
                if (resp_delay == 0) begin
                    read_data_valid = 1'b1;
                    read_data = resp_word;
                    resp_pending = 1'b0;
                end else begin
                    resp_delay--;
                end
            end
            // random stalls of at most max_stall cycles
            if (stall_run >= max_stall) begin
                ready = 1'b1;
            end else begin
                ready = ($urandom % 3) != 0;
            end
            stall_run = ready ? 0 : stall_run + 1;
            held_valid = mem_req.read_req || mem_req.write_req;
            held_req = mem_req;
            assert (!(held_valid && quiet_phase)) else
                stop_run("the core raised a bus request after the halting instruction");
            if (held_valid && !first_req_seen) begin
                first_req_seen = 1'b1;
                assert (mem_req.read_req && !mem_req.write_req && mem_req.addr == reset_pc &&
                        mem_req.byte_enable == 4'hf) else
                    stop_run($sformatf("[FAIL] %0t ns: first request after reset is %h",
                                       $time, mem_req));
            end
        end
    end

    initial begin
        void'($urandom(54));
        clk = 1'b0;
        reset_n = 1'b0;
        ready = 1'b0;
        read_data = '0;
        read_data_valid = 1'b0;
        stores_seen = 0;
        reads_after_stores = 0;
        first_req_seen = 1'b0;
        quiet_phase = 1'b0;
        $readmemh("tb/core_trace.txt", trace);
        num_words = int'(trace[0]);
        num_stores = int'(trace[1]);
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (reset_pc + 32'(4 * i)) ^ 32'h5a5a_5a5a;
        end
        for (int i = 0; i < num_words; i++) begin
            mem[i] = trace[2+i];
        end
        trace_loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        wait (stores_seen == num_stores && reads_after_stores == tail_fetches);
        quiet_phase = 1'b1;
        repeat (quiet_cycles) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

    // watchdog
    initial begin
        int limit_cycles;
        wait (trace_loaded);
        limit_cycles = reset_cycles + num_words * worst_cycles_per_instr + quiet_cycles + 10;
        #(limit_cycles * cycle_ns);
        stop_run("timeout, the program did not finish within the expected number of cycles");
    end

endmodule

`default_nettype wire
